/* vlog.f */
hw/exu_pkg.sv
hw/exu_br_pkg.sv
hw/exu_operand_sel.sv
hw/exu_alu.sv
hw/exu_r_pipe.sv
hw/exu_top.sv
testbench/tb_exu.sv

/* testbench/exu_input.txt */
# name alu_op br_op valid branch rs1_en rs2_en sel_pc gpr_rs1 gpr_rs2 immed byp1 byp2 byp_src
# pc br_imm pred_taken flush_lower flush_path_r npc_x exp_result exp_flush exp_path exp_npc
add 0 0 1 0 1 1 0 1234 fff 0 0 0 0 100 10 0 0 0 0 2233 0 102 102
sub_imm 1 0 1 0 1 0 0 10 deadbeef 20 0 0 0 100 10 0 0 0 0 fffffff0 0 102 102
slt 5 0 1 0 1 1 0 ffffffff 1 0 0 0 0 100 10 0 0 0 0 1 0 102 102
sll 7 0 1 0 1 1 0 3 24 0 0 0 0 100 10 0 0 0 0 30 0 102 102
srl 8 0 1 0 1 1 0 80000000 1f 0 0 0 0 100 10 0 0 0 0 1 0 102 102
byp_r_and 2 0 1 0 1 1 0 11111111 ff00ff00 0 1 0 f0f0f0f0 100 10 0 0 0 0 f000f000 0 102 102
byp_m_or 3 0 1 0 1 1 0 12340000 99999999 0 0 2 5678 100 10 0 0 0 0 12345678 0 102 102
byp_nb_xor 4 0 1 0 1 1 0 0 f0f0f0f 0 8 0 ffff0000 100 10 0 0 0 0 f0f00f0f 0 102 102
byp_x_sltu 6 0 1 0 1 1 0 1 77777777 0 0 4 0 100 10 0 0 0 0 1 0 102 102
pc_sel_add 0 0 1 0 1 0 1 55555555 66666666 40 0 0 0 100 10 0 0 0 0 240 0 102 102
beq_t_pnt 1 0 1 1 1 1 0 5 5 0 0 0 0 200 20 0 0 0 abc 0 1 220 220
beq_t_pt 1 0 1 1 1 1 0 5 5 0 0 0 0 200 20 1 0 0 abc 0 0 220 abc
beq_nt_pt 1 0 1 1 1 1 0 5 6 0 0 0 0 200 20 1 0 0 abc ffffffff 1 202 202
beq_nt_pnt 1 0 1 1 1 1 0 5 6 0 0 0 0 200 20 0 0 0 abc ffffffff 0 202 abc
bne_t_pnt 1 1 1 1 1 1 0 5 6 0 0 0 0 200 20 0 0 0 abc ffffffff 1 220 220
bne_t_pt 1 1 1 1 1 1 0 5 6 0 0 0 0 200 20 1 0 0 abc ffffffff 0 220 abc
bne_nt_pt 1 1 1 1 1 1 0 5 5 0 0 0 0 200 20 1 0 0 abc 0 1 202 202
bne_nt_pnt 1 1 1 1 1 1 0 5 5 0 0 0 0 200 20 0 0 0 abc 0 0 202 abc
blt_t_pnt 1 2 1 1 1 1 0 fffffff0 3 0 0 0 0 200 ff0 0 0 0 abc ffffffed 1 1f0 1f0
blt_t_pt 1 2 1 1 1 1 0 fffffff0 3 0 0 0 0 200 ff0 1 0 0 abc ffffffed 0 1f0 abc
blt_nt_pt 1 2 1 1 1 1 0 3 fffffff0 0 0 0 0 200 ff0 1 0 0 abc 13 1 202 202
blt_nt_pnt 1 2 1 1 1 1 0 3 fffffff0 0 0 0 0 200 ff0 0 0 0 abc 13 0 202 abc
bge_t_pnt 1 3 1 1 1 1 0 3 fffffff0 0 0 0 0 200 ff0 0 0 0 abc 13 1 1f0 1f0
bge_t_pt 1 3 1 1 1 1 0 3 fffffff0 0 0 0 0 200 ff0 1 0 0 abc 13 0 1f0 abc
bge_nt_pt 1 3 1 1 1 1 0 fffffff0 3 0 0 0 0 200 ff0 1 0 0 abc ffffffed 1 202 202
bge_nt_pnt 1 3 1 1 1 1 0 fffffff0 3 0 0 0 0 200 ff0 0 0 0 abc ffffffed 0 202 abc
lower_beq 1 0 1 1 1 1 0 5 5 0 0 0 0 200 20 0 1 400 abc 0 1 400 220
lower_bne 1 1 1 1 1 1 0 1 2 0 0 0 0 200 20 0 1 500 abc ffffffff 1 500 220

/* testbench/tb_exu.sv */
`timescale 1ns/1ns
/*
 * Testbench for the execute unit: vectors read from a text file,
 * X-stage results and R-stage next PC checked per vector
 */
module tb_exu
   import exu_pkg::*;
   import exu_br_pkg::*;
();

   localparam int MAX_VECTORS    = 64;
   localparam int TIMEOUT_MARGIN = 20;       // Reset and drain cycles
   localparam int NUM_FIELDS     = 23;       // Hex fields after the name

   logic                clk;
   logic                i_arst_n;
   logic                i_x_data_en;
   logic                i_r_data_en;
   logic                i_valid_d;
   logic                i_branch_d;
   alu_op_e             i_alu_op_d;
   br_op_e              i_br_op_d;
   logic                i_pred_taken_d;
   logic [XLEN_DEF-1:0] i_gpr_rs1_d;
   logic [XLEN_DEF-1:0] i_gpr_rs2_d;
   logic [XLEN_DEF-1:0] i_immed_d;
   logic                i_rs1_en_d;
   logic                i_rs2_en_d;
   logic                i_select_pc_d;
   logic [PC_W-1:0]     i_pc_d;
   logic [3:0]          i_rs1_bypass_en_d;
   logic [3:0]          i_rs2_bypass_en_d;
   logic [XLEN_DEF-1:0] i_result_r;
   logic [XLEN_DEF-1:0] i_lsu_result_m;
   logic [XLEN_DEF-1:0] i_nb_load_data;
   logic [BR_IMM_W-1:0] i_br_imm_d;
   logic                i_flush_lower_r;
   logic [PC_W-1:0]     i_flush_path_r;
   logic [PC_W-1:0]     i_pred_correct_npc_x;
   logic [XLEN_DEF-1:0] o_result_x;
   logic [PC_W-1:0]     o_pc_x;
   logic                o_flush_final;
   logic [PC_W-1:0]     o_flush_path_final;
   logic [PC_W-1:0]     o_npc_r;

   logic [8*256-1:0]    vectors[$];          // Raw vector lines
   logic [8*16-1:0]     test_name;
   logic [31:0]         f[NUM_FIELDS];       // Parsed fields of one vector
   logic [31:0]         seed_value;
   logic                test_ok;
   int                  cycle_count;
   int                  cycle_limit;
   int                  test_count;
   int                  fail_count;
   int                  error_count;

   exu_top #(.XLEN(XLEN_DEF)) exu_top_i (.*);

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("Timeout: run stopped after %0d cycles", cycle_count);
         $display("Simulation FAILED");
         $finish;
      end
   end

   task automatic check_value(input logic [8*12-1:0] what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("** Error %0s %0s: expected %h, actual %h", test_name, what,
                  expected, actual);
         error_count++;
         test_ok = 1'b0;
      end
   endtask

   task automatic report_test();
      test_count++;
      if (test_ok) begin
         $display("Test %0s ok", test_name);
      end else begin
         fail_count++;
         $display("Test %0s failed", test_name);
      end
   endtask

   task automatic read_vectors();
      int               fd;
      int               n;
      logic [8*256-1:0] line_buf;
      logic [8*16-1:0]  first_word;
      fd = $fopen("testbench/exu_input.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the vector file testbench/exu_input.txt");
      end else begin
         while (!$feof(fd)) begin
            line_buf = '0;
            if ($fgets(line_buf, fd) != 0) begin
               n = $sscanf(line_buf, "%s", first_word);
               if (n == 1 && first_word != "#" && vectors.size() < MAX_VECTORS)
                  vectors.push_back(line_buf);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic apply_vector(input logic [8*256-1:0] text);
      int         n;
      logic [3:0] byp_sel;
      test_ok = 1'b1;
      n = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  test_name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                  f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                  f[20], f[21], f[22]);
      if (n != NUM_FIELDS + 1) begin
         $display("A vector line could not be parsed, %0d fields found", n);
         error_count++;
         test_ok = 1'b0;
         return;
      end
      byp_sel = f[10][3:0] | f[11][3:0];     // Source that the vector sets
      @(posedge clk);
      i_alu_op_d           <= alu_op_e'(f[0][3:0]);
      i_br_op_d            <= br_op_e'(f[1][1:0]);
      i_valid_d            <= f[2][0];
      i_branch_d           <= f[3][0];
      i_rs1_en_d           <= f[4][0];
      i_rs2_en_d           <= f[5][0];
      i_select_pc_d        <= f[6][0];
      i_gpr_rs1_d          <= f[7];
      i_gpr_rs2_d          <= f[8];
      i_immed_d            <= f[9];
      i_rs1_bypass_en_d    <= f[10][3:0];
      i_rs2_bypass_en_d    <= f[11][3:0];
      i_result_r           <= byp_sel[0] ? f[12] : $urandom();
      i_lsu_result_m       <= byp_sel[1] ? f[12] : $urandom();
      i_nb_load_data       <= byp_sel[3] ? f[12] : $urandom();
      i_pc_d               <= f[13][PC_W-1:0];
      i_br_imm_d           <= f[14][BR_IMM_W-1:0];
      i_pred_taken_d       <= f[15][0];
      i_flush_lower_r      <= f[16][0];
      i_flush_path_r       <= f[16][0] ? f[17][PC_W-1:0] : PC_W'($urandom());
      i_pred_correct_npc_x <= f[18][PC_W-1:0];
      i_x_data_en          <= 1'b1;
      @(posedge clk);                        // D sampled into X
      i_x_data_en <= 1'b0;
      i_r_data_en <= 1'b1;
      @(negedge clk);
      check_value("result", f[19], o_result_x);
      check_value("flush", f[20], o_flush_final);
      check_value("flush_path", f[21], o_flush_path_final);
      check_value("pc", 32'(f[13][PC_W-1:0]), o_pc_x);
      @(posedge clk);                        // X state into R
      i_r_data_en <= 1'b0;
      @(negedge clk);
      check_value("npc", f[22], o_npc_r);
   endtask

   initial begin
      clk                  = 1'b0;
      i_arst_n             = 1'b0;
      i_x_data_en          = 1'b0;
      i_r_data_en          = 1'b0;
      i_valid_d            = 1'b0;
      i_branch_d           = 1'b0;
      i_alu_op_d           = ALU_ADD;
      i_br_op_d            = BR_EQ;
      i_pred_taken_d       = 1'b0;
      i_gpr_rs1_d          = '0;
      i_gpr_rs2_d          = '0;
      i_immed_d            = '0;
      i_rs1_en_d           = 1'b0;
      i_rs2_en_d           = 1'b0;
      i_select_pc_d        = 1'b0;
      i_pc_d               = '0;
      i_rs1_bypass_en_d    = '0;
      i_rs2_bypass_en_d    = '0;
      i_result_r           = '0;
      i_lsu_result_m       = '0;
      i_nb_load_data       = '0;
      i_br_imm_d           = '0;
      i_flush_lower_r      = 1'b0;
      i_flush_path_r       = '0;
      i_pred_correct_npc_x = '0;
      cycle_count          = 0;
      test_count           = 0;
      fail_count           = 0;
      error_count          = 0;
      cycle_limit          = 4 * MAX_VECTORS + TIMEOUT_MARGIN;
      seed_value           = $urandom(32'hc107);
      read_vectors();
      cycle_limit = 4 * vectors.size() + TIMEOUT_MARGIN;  // Three cycles per vector
      repeat (2) @(posedge clk);
      i_arst_n <= 1'b1;
      @(negedge clk);
      test_name = "reset";
      test_ok   = 1'b1;
      check_value("flush", 32'd0, o_flush_final);
      check_value("npc", 32'd0, o_npc_r);
      report_test();
      foreach (vectors[i]) begin
         apply_vector(vectors[i]);
         report_test();
      end
      if (vectors.size() == 0) begin
         $display("No test vectors were read");
         fail_count++;
      end
      $display("Tests run: %0d, failed: %0d, check errors: %0d", test_count, fail_count,
               error_count);
      if (fail_count == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

/* hw/exu_top.sv */
`timescale 1ns/1ns
/*
 * Execute unit top: operand select, X-stage ALU and branch
 * resolve, R-stage next-PC register
 */
module exu_top
   import exu_pkg::*;
   import exu_br_pkg::*;
#(
   parameter int XLEN = XLEN_DEF
) (
   input  logic                clk,
   input  logic                i_arst_n,
   input  logic                i_x_data_en,
   input  logic                i_r_data_en,
   input  logic                i_valid_d,
   input  logic                i_branch_d,
   input  alu_op_e             i_alu_op_d,
   input  br_op_e              i_br_op_d,
   input  logic                i_pred_taken_d,
   input  logic [XLEN-1:0]     i_gpr_rs1_d,
   input  logic [XLEN-1:0]     i_gpr_rs2_d,
   input  logic [XLEN-1:0]     i_immed_d,
   input  logic                i_rs1_en_d,
   input  logic                i_rs2_en_d,
   input  logic                i_select_pc_d,
   input  logic [PC_W-1:0]     i_pc_d,
   input  logic [3:0]          i_rs1_bypass_en_d,
   input  logic [3:0]          i_rs2_bypass_en_d,
   input  logic [XLEN-1:0]     i_result_r,
   input  logic [XLEN-1:0]     i_lsu_result_m,
   input  logic [XLEN-1:0]     i_nb_load_data,
   input  logic [BR_IMM_W-1:0] i_br_imm_d,
   input  logic                i_flush_lower_r,
   input  logic [PC_W-1:0]     i_flush_path_r,
   input  logic [PC_W-1:0]     i_pred_correct_npc_x,
   output logic [XLEN-1:0]     o_result_x,
   output logic [PC_W-1:0]     o_pc_x,
   output logic                o_flush_final,
   output logic [PC_W-1:0]     o_flush_path_final,
   output logic [PC_W-1:0]     o_npc_r
);

   logic [XLEN-1:0] rs1_d;
   logic [XLEN-1:0] rs2_d;
   logic [PC_W-1:0] flush_path_x;
   logic            pred_correct_x;

   exu_operand_sel #(.XLEN(XLEN)) exu_operand_sel_i (
      .clk               (clk),
      .i_arst_n          (i_arst_n),
      .i_gpr_rs1_d       (i_gpr_rs1_d),
      .i_gpr_rs2_d       (i_gpr_rs2_d),
      .i_immed_d         (i_immed_d),
      .i_rs1_en_d        (i_rs1_en_d),
      .i_rs2_en_d        (i_rs2_en_d),
      .i_select_pc_d     (i_select_pc_d),
      .i_pc_d            (i_pc_d),
      .i_rs1_bypass_en_d (i_rs1_bypass_en_d),
      .i_rs2_bypass_en_d (i_rs2_bypass_en_d),
      .i_result_r        (i_result_r),
      .i_lsu_result_m    (i_lsu_result_m),
      .i_result_x        (o_result_x),         // X-stage result fed back
      .i_nb_load_data    (i_nb_load_data),
      .o_rs1_d           (rs1_d),
      .o_rs2_d           (rs2_d)
   );

   exu_alu #(.XLEN(XLEN)) exu_alu_i (
      .clk                (clk),
      .i_arst_n           (i_arst_n),
      .i_x_data_en        (i_x_data_en),
      .i_valid_d          (i_valid_d),
      .i_branch_d         (i_branch_d),
      .i_alu_op_d         (i_alu_op_d),
      .i_br_op_d          (i_br_op_d),
      .i_pred_taken_d     (i_pred_taken_d),
      .i_rs1_d            (rs1_d),
      .i_rs2_d            (rs2_d),
      .i_pc_d             (i_pc_d),
      .i_br_imm_d         (i_br_imm_d),
      .i_flush_lower_r    (i_flush_lower_r),
      .i_flush_path_r     (i_flush_path_r),
      .o_result_x         (o_result_x),
      .o_pc_x             (o_pc_x),
      .o_flush_upper_x    (),                  // Only seen through the final flush
      .o_flush_path_x     (flush_path_x),
      .o_pred_correct_x   (pred_correct_x),
      .o_flush_final      (o_flush_final),
      .o_flush_path_final (o_flush_path_final)
   );

   exu_r_pipe #(.XLEN(XLEN)) exu_r_pipe_i (
      .clk                  (clk),
      .i_arst_n             (i_arst_n),
      .i_r_data_en          (i_r_data_en),
      .i_flush_path_x       (flush_path_x),
      .i_pred_correct_x     (pred_correct_x),
      .i_pred_correct_npc_x (i_pred_correct_npc_x),
      .o_npc_r              (o_npc_r)
   );

endmodule

/* hw/exu_r_pipe.sv */
`timescale 1ns/1ns
/*
 * X-to-R register of the resolved branch state
 * and the R-stage next-PC select
 */
module exu_r_pipe
   import exu_pkg::*;
#(
   parameter int XLEN = XLEN_DEF
) (
   input  logic            clk,
   input  logic            i_arst_n,
   input  logic            i_r_data_en,          // Stage enable X to R
   input  logic [PC_W-1:0] i_flush_path_x,
   input  logic            i_pred_correct_x,
   input  logic [PC_W-1:0] i_pred_correct_npc_x, // Next PC on a correct prediction
   output logic [PC_W-1:0] o_npc_r
);

   logic [PC_W-1:0] flush_path_r;
   logic [PC_W-1:0] pred_correct_npc_r;
   logic            pred_correct_r;

   // PC is a halfword address of the data width
   if (PC_W != XLEN - 1) begin : g_pc_w_check
      $error("PC width %0d does not match data width %0d", PC_W, XLEN);
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pred_correct_r     <= 1'b0;
         flush_path_r       <= '0;
         pred_correct_npc_r <= '0;
      end else if (i_r_data_en) begin
         pred_correct_r     <= i_pred_correct_x;
         flush_path_r       <= i_flush_path_x;
         pred_correct_npc_r <= i_pred_correct_npc_x;
      end
   end

   assign o_npc_r = pred_correct_r ? pred_correct_npc_r : flush_path_r;

   a_npc_known : assert property (@(posedge clk) disable iff (!i_arst_n)
      !$isunknown(o_npc_r))
      else $error("R-stage next PC is unknown");

endmodule

/* hw/exu_alu.sv */
`timescale 1ns/1ns
/*
 * X-stage execute: D-to-X register, integer ALU, conditional
 * branch resolve against the prediction, upper/lower flush merge
 */
module exu_alu
   import exu_pkg::*;
   import exu_br_pkg::*;
#(
   parameter int XLEN = XLEN_DEF
) (
   input  logic                clk,
   input  logic                i_arst_n,
   input  logic                i_x_data_en,        // Stage enable D to X
   input  logic                i_valid_d,
   input  logic                i_branch_d,         // Conditional branch in D
   input  alu_op_e             i_alu_op_d,
   input  br_op_e              i_br_op_d,
   input  logic                i_pred_taken_d,     // Predicted direction
   input  logic [XLEN-1:0]     i_rs1_d,
   input  logic [XLEN-1:0]     i_rs2_d,
   input  logic [PC_W-1:0]     i_pc_d,
   input  logic [BR_IMM_W-1:0] i_br_imm_d,         // Halfword offset
   input  logic                i_flush_lower_r,    // Older flush from R
   input  logic [PC_W-1:0]     i_flush_path_r,
   output logic [XLEN-1:0]     o_result_x,
   output logic [PC_W-1:0]     o_pc_x,
   output logic                o_flush_upper_x,    // Mispredict in X
   output logic [PC_W-1:0]     o_flush_path_x,
   output logic                o_pred_correct_x,
   output logic                o_flush_final,
   output logic [PC_W-1:0]     o_flush_path_final
);

   localparam int SHW = $clog2(XLEN);

   logic [XLEN-1:0]     rs1_x;
   logic [XLEN-1:0]     rs2_x;
   logic [PC_W-1:0]     pc_x;
   logic [BR_IMM_W-1:0] br_imm_x;
   alu_op_e             alu_op_x;
   br_op_e              br_op_x;
   logic                valid_x;
   logic                branch_x;
   logic                pred_taken_x;

   logic                actual_taken_x;
   logic                br_valid_x;
   logic                mispredict_x;
   logic [PC_W-1:0]     target_x;
   logic [PC_W-1:0]     fallthru_x;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         valid_x      <= 1'b0;
         branch_x     <= 1'b0;
         pred_taken_x <= 1'b0;
         alu_op_x     <= ALU_ADD;
         br_op_x      <= BR_EQ;
         rs1_x        <= '0;
         rs2_x        <= '0;
         pc_x         <= '0;
         br_imm_x     <= '0;
      end else if (i_x_data_en) begin
         valid_x      <= i_valid_d;
         branch_x     <= i_branch_d;
         pred_taken_x <= i_pred_taken_d;
         alu_op_x     <= i_alu_op_d;
         br_op_x      <= i_br_op_d;
         rs1_x        <= i_rs1_d;
         rs2_x        <= i_rs2_d;
         pc_x         <= i_pc_d;
         br_imm_x     <= i_br_imm_d;
      end
   end

   always_comb begin
      case (alu_op_x)
         ALU_ADD:  o_result_x = rs1_x + rs2_x;
         ALU_SUB:  o_result_x = rs1_x - rs2_x;
         ALU_AND:  o_result_x = rs1_x & rs2_x;
         ALU_OR:   o_result_x = rs1_x | rs2_x;
         ALU_XOR:  o_result_x = rs1_x ^ rs2_x;
         ALU_SLT:  o_result_x = XLEN'($signed(rs1_x) < $signed(rs2_x));
         ALU_SLTU: o_result_x = XLEN'(rs1_x < rs2_x);
         ALU_SLL:  o_result_x = rs1_x << rs2_x[SHW-1:0];  // Low bits only
         ALU_SRL:  o_result_x = rs1_x >> rs2_x[SHW-1:0];
         default:  o_result_x = '0;
      endcase
   end

   always_comb begin
      case (br_op_x)
         BR_EQ:   actual_taken_x = (rs1_x == rs2_x);
         BR_NE:   actual_taken_x = (rs1_x != rs2_x);
         BR_LT:   actual_taken_x = ($signed(rs1_x) < $signed(rs2_x));
         BR_GE:   actual_taken_x = ($signed(rs1_x) >= $signed(rs2_x));
         default: actual_taken_x = 1'b0;
      endcase
   end

   // Both paths in halfwords, so the offset adds as is and PC+4 is +2
   assign target_x   = pc_x + {{(PC_W-BR_IMM_W){br_imm_x[BR_IMM_W-1]}}, br_imm_x};
   assign fallthru_x = pc_x + PC_W'(2);

   assign br_valid_x   = valid_x & branch_x & ~i_flush_lower_r;  // Killed by older flush
   assign mispredict_x = br_valid_x & (actual_taken_x != pred_taken_x);

   assign o_pc_x           = pc_x;
   assign o_flush_upper_x  = mispredict_x;
   assign o_flush_path_x   = actual_taken_x ? target_x : fallthru_x;
   assign o_pred_correct_x = br_valid_x & ~mispredict_x;

   // R-stage flush is older and wins
   assign o_flush_final      = i_flush_lower_r | o_flush_upper_x;
   assign o_flush_path_final = i_flush_lower_r ? i_flush_path_r : o_flush_path_x;

   // Upper flush rises only for a new X instruction or a released lower flush
   a_upper_masked : assert property (@(posedge clk) disable iff (!i_arst_n)
      $rose(o_flush_upper_x) |-> $past(i_x_data_en) || $fell(i_flush_lower_r))
      else $error("Upper flush raised with no new X instruction or lower flush release");

endmodule

/* hw/exu_operand_sel.sv */
`timescale 1ns/1ns
/*
 * D-stage operand select: one-hot bypass merge from four
 * result sources, then rs1/rs2 choice of bypass, PC, GPR or immediate
 */
module exu_operand_sel
   import exu_pkg::*;
#(
   parameter int XLEN = XLEN_DEF
) (
   input  logic            clk,
   input  logic            i_arst_n,
   input  logic [XLEN-1:0] i_gpr_rs1_d,        // GPR read data
   input  logic [XLEN-1:0] i_gpr_rs2_d,
   input  logic [XLEN-1:0] i_immed_d,          // Decoded immediate
   input  logic            i_rs1_en_d,         // Qualify GPR rs1
   input  logic            i_rs2_en_d,         // Qualify GPR rs2
   input  logic            i_select_pc_d,      // PC onto rs1
   input  logic [PC_W-1:0] i_pc_d,
   input  logic [3:0]      i_rs1_bypass_en_d,  // One-hot bypass select
   input  logic [3:0]      i_rs2_bypass_en_d,
   input  logic [XLEN-1:0] i_result_r,         // R-stage result
   input  logic [XLEN-1:0] i_lsu_result_m,     // M-stage load result
   input  logic [XLEN-1:0] i_result_x,         // X-stage ALU result
   input  logic [XLEN-1:0] i_nb_load_data,     // Non-blocking load data
   output logic [XLEN-1:0] o_rs1_d,
   output logic [XLEN-1:0] o_rs2_d
);

   logic [XLEN-1:0] rs1_byp_data;
   logic [XLEN-1:0] rs2_byp_data;
   logic            rs1_byp_any;
   logic            rs2_byp_any;

   // AND-OR merge, relies on the select being one-hot
   function automatic logic [XLEN-1:0] bypass_merge(
      input logic [3:0]      en,
      input logic [XLEN-1:0] src_r,
      input logic [XLEN-1:0] src_m,
      input logic [XLEN-1:0] src_x,
      input logic [XLEN-1:0] src_nb
   );
      bypass_merge = ({XLEN{en[0]}} & src_r) |
                     ({XLEN{en[1]}} & src_m) |
                     ({XLEN{en[2]}} & src_x) |
                     ({XLEN{en[3]}} & src_nb);
   endfunction

   assign rs1_byp_any  = |i_rs1_bypass_en_d;
   assign rs2_byp_any  = |i_rs2_bypass_en_d;

   assign rs1_byp_data = bypass_merge(i_rs1_bypass_en_d, i_result_r, i_lsu_result_m,
                                      i_result_x, i_nb_load_data);
   assign rs2_byp_data = bypass_merge(i_rs2_bypass_en_d, i_result_r, i_lsu_result_m,
                                      i_result_x, i_nb_load_data);

   always_comb begin
      if (rs1_byp_any) o_rs1_d = rs1_byp_data;
      else if (i_select_pc_d) o_rs1_d = XLEN'({i_pc_d, 1'b0});  // Jumps and auipc
      else if (i_rs1_en_d) o_rs1_d = i_gpr_rs1_d;
      else o_rs1_d = '0;
   end

   always_comb begin
      if (rs2_byp_any) o_rs2_d = rs2_byp_data;
      else if (i_rs2_en_d) o_rs2_d = i_gpr_rs2_d;
      else o_rs2_d = i_immed_d;                // Immediate forms
   end

   a_rs1_byp_onehot : assert property (@(posedge clk) disable iff (!i_arst_n)
      $onehot0(i_rs1_bypass_en_d))
      else $error("rs1 bypass select not one-hot: %b", i_rs1_bypass_en_d);

   a_rs2_byp_onehot : assert property (@(posedge clk) disable iff (!i_arst_n)
      $onehot0(i_rs2_bypass_en_d))
      else $error("rs2 bypass select not one-hot: %b", i_rs2_bypass_en_d);

endmodule

/* hw/exu_br_pkg.sv */
/*
 * Branch definitions: condition opcodes and
 * the width of the halfword branch offset
 */
package exu_br_pkg;

   localparam int BR_IMM_W = 12;             // Offset bits [12:1]

   // Conditional branch compare, rs1 against rs2
   typedef enum logic [1:0] {
      BR_EQ = 2'd0,
      BR_NE = 2'd1,
      BR_LT = 2'd2,                           // Signed
      BR_GE = 2'd3                            // Signed
   } br_op_e;

endpackage

/* hw/exu_pkg.sv */
/*
 * Datapath definitions shared by the execute unit:
 * default data width, halfword PC width, ALU opcodes
 */
package exu_pkg;

   localparam int XLEN_DEF = 32;             // Default data width
   localparam int PC_W     = 31;             // PC bits [31:1], bit 0 implied zero

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_SLT  = 4'd5,                        // Signed less than
      ALU_SLTU = 4'd6,                        // Unsigned less than
      ALU_SLL  = 4'd7,
      ALU_SRL  = 4'd8
   } alu_op_e;

endpackage
